// File: rtl/fe_macros.svh
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// ----------------------------------------------------------------------
// fetch frontend dimensions
// ----------------------------------------------------------------------

// address and instruction width
`define FE_VLEN 32

// instruction slots per fetch, one fetch is 64 bit and 8 byte aligned
`define FE_INSTR_PER_FETCH 2

// fetch queue entries
`define FE_QUEUE_DEPTH 8

// width of the queue occupancy and free-space counters
`define FE_QCNT_W ($clog2(`FE_QUEUE_DEPTH + 1))

`endif

// File: rtl/fe_pkg.sv
`include "fe_macros.svh"

package fe_pkg;

    // ------------------------------------------------------------------
    // predecode path
    // ------------------------------------------------------------------

    // one instruction slot of a fetch, as split out by fetch_reg
    typedef struct packed {
        logic                valid;
        logic [`FE_VLEN-1:0] addr;
        logic [`FE_VLEN-1:0] instr;
    } fe_slot_t;

    // control-flow info from one scanner
    typedef struct packed {
        logic                is_branch;
        logic                is_jal;
        logic                is_jalr;
        // sign-extended B-type or J-type offset
        logic [`FE_VLEN-1:0] imm;
    } cf_info_t;

    // ------------------------------------------------------------------
    // back-end side
    // ------------------------------------------------------------------

    // one instruction handed to the decoder
    typedef struct packed {
        logic [`FE_VLEN-1:0] addr;
        logic [`FE_VLEN-1:0] instr;
        logic                predicted_taken;
        logic [`FE_VLEN-1:0] predict_target;
    } fetch_entry_t;

    // mispredict from the branch unit
    typedef struct packed {
        logic                valid;
        logic [`FE_VLEN-1:0] target;
    } redirect_t;

    // ------------------------------------------------------------------
    // instruction memory port
    // ------------------------------------------------------------------

    typedef struct packed {
        logic                req;
        logic [`FE_VLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                                    valid;
        logic [`FE_VLEN*`FE_INSTR_PER_FETCH-1:0] data;
    } mem_rsp_t;

endpackage

// File: rtl/fetch_reg.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module fetch_reg (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    flush_i,
    input  logic                                    rsp_accept_i,
    input  logic [`FE_VLEN*`FE_INSTR_PER_FETCH-1:0] rsp_data_i,
    input  logic [`FE_VLEN-1:0]                     fetch_addr_i,
    output fe_pkg::fe_slot_t [`FE_INSTR_PER_FETCH-1:0] slots_o
);

    // bits of the address that select a word inside one fetch
    localparam int unsigned OW = $clog2(`FE_INSTR_PER_FETCH);

    logic [`FE_VLEN*`FE_INSTR_PER_FETCH-1:0] data_q;
    logic [`FE_VLEN-1:0]                     addr_q;
    logic                                    valid_q;

    // valid lives for one cycle only, so every fetch is presented once
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rsp_accept_i & ~flush_i;
        end
    end

    // payload is only meaningful while valid_q is set
    always_ff @(posedge clk_i) begin
        if (rsp_accept_i) begin
            data_q <= rsp_data_i;
            addr_q <= fetch_addr_i;
        end
    end

    // ------------------------------------------------------------------
    // slot split
    // ------------------------------------------------------------------
    always_comb begin
        for (int unsigned i = 0; i < `FE_INSTR_PER_FETCH; i++) begin
            slots_o[i].addr  = {addr_q[`FE_VLEN-1:OW+2], OW'(i), 2'b00};
            slots_o[i].instr = data_q[i*`FE_VLEN +: `FE_VLEN];
            // words below the entry point of a redirected fetch are skipped
            slots_o[i].valid = valid_q && (addr_q[2 +: OW] <= OW'(i));
        end
    end

endmodule

// File: rtl/instr_scan.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module instr_scan (
    input  logic [`FE_VLEN-1:0] instr_i,
    output fe_pkg::cf_info_t    cf_o
);

    // ------------------------------------------------------------------
    // RVI control-flow opcodes
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0]          opcode;
    logic [`FE_VLEN-1:0] imm_b;
    logic [`FE_VLEN-1:0] imm_j;

    assign opcode = instr_i[6:0];

    // B-type offset, bit 0 is implicit
    assign imm_b = {
        {(`FE_VLEN-12){instr_i[31]}},
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    // J-type offset, also halfword granular
    assign imm_j = {
        {(`FE_VLEN-20){instr_i[31]}},
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

    always_comb begin
        cf_o.is_branch = (opcode == OPC_BRANCH);
        cf_o.is_jal    = (opcode == OPC_JAL);
        cf_o.is_jalr   = (opcode == OPC_JALR);
        // jalr target depends on a register, its imm is never used
        cf_o.imm       = cf_o.is_jal ? imm_j : imm_b;
    end

endmodule

// File: rtl/branch_predict.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module branch_predict (
    input  fe_pkg::fe_slot_t     [`FE_INSTR_PER_FETCH-1:0] slots_i,
    input  fe_pkg::cf_info_t     [`FE_INSTR_PER_FETCH-1:0] cf_i,
    output logic                 [`FE_INSTR_PER_FETCH-1:0] wr_en_o,
    output fe_pkg::fetch_entry_t [`FE_INSTR_PER_FETCH-1:0] entries_o,
    output logic                                           predict_valid_o,
    output logic                 [`FE_VLEN-1:0]            predict_target_o
);

    // per-slot static decision
    logic [`FE_INSTR_PER_FETCH-1:0] taken;

    // jal always, a conditional branch only when it jumps backwards
    // jalr has no target here and falls through as not taken
    always_comb begin
        for (int i = 0; i < `FE_INSTR_PER_FETCH; i++) begin
            taken[i] = slots_i[i].valid &&
                       (cf_i[i].is_jal || (cf_i[i].is_branch && cf_i[i].imm[`FE_VLEN-1]));
        end
    end

    // ------------------------------------------------------------------
    // lowest taken slot wins, younger slots are trimmed
    // ------------------------------------------------------------------
    always_comb begin
        logic hit;

        hit              = 1'b0;
        predict_valid_o  = 1'b0;
        predict_target_o = '0;

        for (int i = 0; i < `FE_INSTR_PER_FETCH; i++) begin
            entries_o[i].addr            = slots_i[i].addr;
            entries_o[i].instr           = slots_i[i].instr;
            entries_o[i].predicted_taken = 1'b0;
            // not-taken entries carry their fall-through address
            entries_o[i].predict_target  = slots_i[i].addr + `FE_VLEN'(4);

            wr_en_o[i] = slots_i[i].valid && !hit;

            if (taken[i] && !hit) begin
                hit                          = 1'b1;
                entries_o[i].predicted_taken = 1'b1;
                entries_o[i].predict_target  = slots_i[i].addr + cf_i[i].imm;
                predict_valid_o              = 1'b1;
                predict_target_o             = entries_o[i].predict_target;
            end
        end
    end

endmodule

// File: rtl/instr_queue.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module instr_queue (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    input  logic                 [`FE_INSTR_PER_FETCH-1:0] wr_en_i,
    input  fe_pkg::fetch_entry_t [`FE_INSTR_PER_FETCH-1:0] entries_i,
    input  logic                                           fetch_entry_ready_i,
    output fe_pkg::fetch_entry_t                           fetch_entry_o,
    output logic                                           fetch_entry_valid_o,
    output logic                 [`FE_QCNT_W-1:0]          free_count_o
);

    localparam int unsigned PTR_W = $clog2(`FE_QUEUE_DEPTH);

    fe_pkg::fetch_entry_t mem_q [`FE_QUEUE_DEPTH];

    logic [PTR_W-1:0]      rd_ptr_q, wr_ptr_q;
    logic [`FE_QCNT_W-1:0] count_q;
    logic [`FE_QCNT_W-1:0] n_wr;
    logic [PTR_W-1:0]      wr_idx [`FE_INSTR_PER_FETCH];
    logic                  pop;

    // ------------------------------------------------------------------
    // write compaction
    // ------------------------------------------------------------------
    // enabled slots are packed back to back starting at wr_ptr_q
    always_comb begin
        n_wr = '0;
        for (int i = 0; i < `FE_INSTR_PER_FETCH; i++) begin
            wr_idx[i] = wr_ptr_q + PTR_W'(n_wr);
            if (wr_en_i[i]) begin
                n_wr = n_wr + 1'b1;
            end
        end
    end

    assign fetch_entry_o       = mem_q[rd_ptr_q];
    assign fetch_entry_valid_o = (count_q != '0);
    assign free_count_o        = `FE_QCNT_W'(`FE_QUEUE_DEPTH) - count_q;
    assign pop                 = fetch_entry_valid_o & fetch_entry_ready_i;

    // flush drops the queue together with anything written this cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop);
            wr_ptr_q <= wr_ptr_q + PTR_W'(n_wr);
            count_q  <= count_q + n_wr - `FE_QCNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `FE_INSTR_PER_FETCH; i++) begin
            if (wr_en_i[i] && !flush_i) begin
                mem_q[wr_idx[i]] <= entries_i[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    // pc_gen only issues when a whole fetch fits
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !flush_i |-> n_wr <= free_count_o);

    // held entry must not change under back-pressure
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_entry_valid_o && !fetch_entry_ready_i && !flush_i
        |=> fetch_entry_valid_o && $stable(fetch_entry_o));

endmodule

// File: rtl/pc_gen.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module pc_gen (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [`FE_VLEN-1:0]   boot_addr_i,
    input  logic                  mem_rsp_valid_i,
    input  logic                  predict_valid_i,
    input  logic [`FE_VLEN-1:0]   predict_target_i,
    input  fe_pkg::redirect_t     resolved_i,
    input  logic                  eret_i,
    input  logic [`FE_VLEN-1:0]   epc_i,
    input  logic                  ex_valid_i,
    input  logic [`FE_VLEN-1:0]   trap_vector_i,
    input  logic [`FE_QCNT_W-1:0] free_count_i,
    output fe_pkg::mem_req_t      mem_req_o,
    output logic                  rsp_accept_o,
    output logic [`FE_VLEN-1:0]   fetch_addr_o,
    output logic                  flush_o
);

    logic [`FE_VLEN-1:0] npc_d, npc_q, fetch_addr_q, base_addr, aligned_addr;
    logic                rst_load_q, outstanding_q, stale_q, present_q;
    logic                issue;

    // any back-end redirect empties the whole frontend
    assign flush_o = resolved_i.valid | eret_i | ex_valid_i;

    // boot address is taken once, right after reset
    assign base_addr    = rst_load_q ? boot_addr_i : npc_q;
    assign aligned_addr = {base_addr[`FE_VLEN-1:3], 3'b000};

    // present_q covers the cycle fetch_reg writes the queue, so the
    // free count seen here already includes that fetch
    assign issue = !outstanding_q && !present_q && !flush_o &&
                   (free_count_i >= `FE_QCNT_W'(`FE_INSTR_PER_FETCH));

    assign mem_req_o.req  = issue;
    assign mem_req_o.addr = aligned_addr;
    assign rsp_accept_o   = mem_rsp_valid_i && outstanding_q && !stale_q && !flush_o;
    assign fetch_addr_o   = fetch_addr_q;

    // ------------------------------------------------------------------
    // next pc, later lines win
    // ------------------------------------------------------------------
    always_comb begin
        npc_d = base_addr;
        if (issue)            npc_d = aligned_addr + `FE_VLEN'(8);
        if (predict_valid_i)  npc_d = predict_target_i;
        if (resolved_i.valid) npc_d = resolved_i.target;
        if (eret_i)           npc_d = epc_i;
        if (ex_valid_i)       npc_d = trap_vector_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q         <= '0;
            rst_load_q    <= 1'b1;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
            present_q     <= 1'b0;
        end else begin
            npc_q      <= npc_d;
            rst_load_q <= 1'b0;
            present_q  <= rsp_accept_o;
            if (issue) begin
                outstanding_q <= 1'b1;
                stale_q       <= 1'b0;
            end else if (mem_rsp_valid_i) begin
                outstanding_q <= 1'b0;
                stale_q       <= 1'b0;
            end else if (outstanding_q && (flush_o || predict_valid_i)) begin
                // response still comes back but gets dropped
                stale_q <= 1'b1;
            end
        end
    end

    // word offset is kept so fetch_reg can skip the leading slots
    always_ff @(posedge clk_i) begin
        if (issue) begin
            fetch_addr_q <= base_addr;
        end
    end

    // memory must answer only what was asked
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_valid_i |-> outstanding_q);

endmodule

// File: rtl/fetch_frontend.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module fetch_frontend (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [`FE_VLEN-1:0]  boot_addr_i,
    output fe_pkg::mem_req_t     mem_req_o,
    input  fe_pkg::mem_rsp_t     mem_rsp_i,
    input  fe_pkg::redirect_t    resolved_i,
    input  logic                 eret_i,
    input  logic [`FE_VLEN-1:0]  epc_i,
    input  logic                 ex_valid_i,
    input  logic [`FE_VLEN-1:0]  trap_vector_i,
    output fe_pkg::fetch_entry_t fetch_entry_o,
    output logic                 fetch_entry_valid_o,
    input  logic                 fetch_entry_ready_i
);

    logic                  flush, rsp_accept, predict_valid;
    logic [`FE_VLEN-1:0]   fetch_addr, predict_target;
    logic [`FE_QCNT_W-1:0] free_count;

    fe_pkg::fe_slot_t     [`FE_INSTR_PER_FETCH-1:0] slots;
    fe_pkg::cf_info_t     [`FE_INSTR_PER_FETCH-1:0] cf;
    fe_pkg::fetch_entry_t [`FE_INSTR_PER_FETCH-1:0] entries;
    logic                 [`FE_INSTR_PER_FETCH-1:0] wr_en;

    // ------------------------------------------------------------------
    // request side
    // ------------------------------------------------------------------
    pc_gen i_pc_gen (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .boot_addr_i      (boot_addr_i),
        .mem_rsp_valid_i  (mem_rsp_i.valid),
        .predict_valid_i  (predict_valid),
        .predict_target_i (predict_target),
        .resolved_i       (resolved_i),
        .eret_i           (eret_i),
        .epc_i            (epc_i),
        .ex_valid_i       (ex_valid_i),
        .trap_vector_i    (trap_vector_i),
        .free_count_i     (free_count),
        .mem_req_o        (mem_req_o),
        .rsp_accept_o     (rsp_accept),
        .fetch_addr_o     (fetch_addr),
        .flush_o          (flush)
    );

    fetch_reg i_fetch_reg (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush),
        .rsp_accept_i (rsp_accept),
        .rsp_data_i   (mem_rsp_i.data),
        .fetch_addr_i (fetch_addr),
        .slots_o      (slots)
    );

    // ------------------------------------------------------------------
    // predecode and prediction
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `FE_INSTR_PER_FETCH; i++) begin : gen_instr_scan
        instr_scan i_instr_scan (
            .instr_i (slots[i].instr),
            .cf_o    (cf[i])
        );
    end

    branch_predict i_branch_predict (
        .slots_i          (slots),
        .cf_i             (cf),
        .wr_en_o          (wr_en),
        .entries_o        (entries),
        .predict_valid_o  (predict_valid),
        .predict_target_o (predict_target)
    );

    // toward decode
    instr_queue i_instr_queue (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush),
        .wr_en_i             (wr_en),
        .entries_i           (entries),
        .fetch_entry_ready_i (fetch_entry_ready_i),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_entry_valid_o (fetch_entry_valid_o),
        .free_count_o        (free_count)
    );

endmodule

// File: dv/tb_fetch_frontend.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module tb_fetch_frontend;

    localparam int NUM_TESTS   = 9;
    // budget of 400 cycles for every test
    localparam int CYCLE_LIMIT = NUM_TESTS * 400;

    logic                 clk_i = 1'b0;
    logic                 rst_ni;
    logic [`FE_VLEN-1:0]  boot_addr_i;
    logic [`FE_VLEN-1:0]  epc_i;
    logic [`FE_VLEN-1:0]  trap_vector_i;
    logic                 eret_i;
    logic                 ex_valid_i;
    fe_pkg::redirect_t    resolved_i;
    fe_pkg::mem_req_t     mem_req_o;
    fe_pkg::mem_rsp_t     mem_rsp_i = '0;
    fe_pkg::fetch_entry_t fetch_entry_o;
    logic                 fetch_entry_valid_o;
    logic                 fetch_entry_ready_i = 1'b0;

    // program image, 4 KiB of words
    logic [31:0]          imem [1024];
    fe_pkg::fetch_entry_t exp_q [$];
    logic [31:0]          rsp_addr;
    int                   rsp_wait = 0;
    int                   cycles = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   tests_done = 0;
    bit                   req_seen = 1'b0;
    bit                   stall_mode = 1'b0;

    always #2 clk_i = ~clk_i;

    fetch_frontend dut_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .boot_addr_i         (boot_addr_i),
        .mem_req_o           (mem_req_o),
        .mem_rsp_i           (mem_rsp_i),
        .resolved_i          (resolved_i),
        .eret_i              (eret_i),
        .epc_i               (epc_i),
        .ex_valid_i          (ex_valid_i),
        .trap_vector_i       (trap_vector_i),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_entry_valid_o (fetch_entry_valid_o),
        .fetch_entry_ready_i (fetch_entry_ready_i)
    );

    // ------------------------------------------------------------------
    // program image
    // ------------------------------------------------------------------
    // op-imm word built from the full address, never control flow
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[31:7] ^ a[24:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] img_word(input logic [31:0] a);
        return imem[a[11:2]];
    endfunction

    function automatic logic [31:0] enc_jal(input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_branch(input int off, input logic [2:0] f3);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, f3, o[4:1], o[11], 7'b1100011};
    endfunction

    task automatic build_image();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = fill_word(32'(i) << 2);
        end
        // jal in slot 0 and slot 1, backward bne landing on a second word
        imem[32'h200 >> 2] = enc_jal('h20);
        imem[32'h224 >> 2] = enc_branch(-'h18, 3'b001);
        imem[32'h214 >> 2] = enc_jal('hec);
        // forward branches and jalr all fall through
        imem[32'h400 >> 2] = enc_branch('h40, 3'b000);
        imem[32'h404 >> 2] = {12'h000, 5'd1, 3'b000, 5'd0, 7'b1100111};
        imem[32'h408 >> 2] = enc_branch('h8, 3'b100);
        imem[32'h414 >> 2] = {12'h010, 5'd5, 3'b000, 5'd0, 7'b1100111};
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // one step of the static rule, target doubles as the next pc
    function automatic fe_pkg::fetch_entry_t ref_entry(input logic [31:0] pc);
        fe_pkg::fetch_entry_t e;
        logic [31:0]          w;
        int                   off;
        logic                 taken;
        w     = img_word(pc);
        off   = 0;
        taken = 1'b0;
        case (w[6:0])
            7'b1101111: begin
                off   = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
                taken = 1'b1;
            end
            7'b1100011: begin
                off   = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
                taken = (off < 0);
            end
            default: ;
        endcase
        e.addr            = pc;
        e.instr           = w;
        e.predicted_taken = taken;
        e.predict_target  = taken ? pc + off : pc + 32'd4;
        return e;
    endfunction

    task automatic load_expected(input logic [31:0] start, input int n);
        fe_pkg::fetch_entry_t e;
        logic [31:0]          pc;
        pc = start;
        for (int k = 0; k < n; k++) begin
            e = ref_entry(pc);
            exp_q.push_back(e);
            pc = e.predict_target;
        end
    endtask

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    // one entry as text for the error lines
    function automatic string format_entry(input fe_pkg::fetch_entry_t e);
        return $sformatf("addr=%h instr=%h taken=%b target=%h",
                         e.addr, e.instr, e.predicted_taken, e.predict_target);
    endfunction

    task automatic check_entry(input fe_pkg::fetch_entry_t got, input fe_pkg::fetch_entry_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: fetch_entry_o exp %s got %s",
                     $time, format_entry(exp), format_entry(got));
        end
    endtask

    task automatic check_req(input fe_pkg::mem_req_t got, input fe_pkg::mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: mem_req_o exp req=%b addr=%h got req=%b addr=%h",
                     $time, exp.req, exp.addr, got.req, got.addr);
        end
    endtask

    // ------------------------------------------------------------------
    // memory model, one fetch in flight, 1 to 3 cycles latency
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        mem_rsp_i.valid <= 1'b0;
        if (!rst_ni) begin
            rsp_wait = 0;
        end else begin
            if (rsp_wait == 1) begin
                mem_rsp_i.valid <= 1'b1;
                mem_rsp_i.data  <= {img_word(rsp_addr + 32'd4), img_word(rsp_addr)};
            end
            if (rsp_wait > 0) begin
                rsp_wait = rsp_wait - 1;
            end
            if (mem_req_o.req) begin
                // first fetch out of reset goes to the aligned boot address
                if (!req_seen) begin
                    check_req(mem_req_o, '{req: 1'b1, addr: {boot_addr_i[31:3], 3'b000}});
                    req_seen = 1'b1;
                end
                rsp_addr = mem_req_o.addr;
                rsp_wait = 1 + int'($urandom % 3);
            end
        end
    end

    // back-end side, pops the expected stream on every transfer
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            fetch_entry_ready_i <= 1'b0;
        end else begin
            if (fetch_entry_valid_o && fetch_entry_ready_i) begin
                check_entry(fetch_entry_o, exp_q.pop_front());
            end
            // ready drops once the expected stream is used up
            fetch_entry_ready_i <= (exp_q.size() != 0) &&
                                   (!stall_mode || ($urandom % 2 == 0));
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: stream still incomplete after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // test sequencing
    // ------------------------------------------------------------------
    task automatic finish_test(input string name, input int err0);
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        tests_done++;
        if (errors == err0) begin
            $display("test %0d %s: ok", tests_done, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, name, errors - err0);
        end
    endtask

    // one-cycle redirect pulse, then the stream from the winning target
    task automatic redirect_test(input string name, input logic mis, input logic eret,
                                 input logic ex, input logic [31:0] mis_t,
                                 input logic [31:0] epc, input logic [31:0] trap,
                                 input int n, input bit stall);
        int          err0;
        logic [31:0] start;
        err0 = errors;
        @(posedge clk_i);
        resolved_i    <= '{valid: mis, target: mis_t};
        eret_i        <= eret;
        epc_i         <= epc;
        ex_valid_i    <= ex;
        trap_vector_i <= trap;
        @(posedge clk_i);
        resolved_i    <= '0;
        eret_i        <= 1'b0;
        ex_valid_i    <= 1'b0;
        // exception over eret over mispredict
        start = ex ? trap : (eret ? epc : mis_t);
        @(negedge clk_i);
        stall_mode = stall;
        load_expected(start, n);
        finish_test(name, err0);
    endtask

    initial begin
        int err0;
        void'($urandom(32'heb60));
        rst_ni        = 1'b0;
        boot_addr_i   = 32'h100;
        resolved_i    = '0;
        eret_i        = 1'b0;
        epc_i         = '0;
        ex_valid_i    = 1'b0;
        trap_vector_i = '0;
        build_image();
        err0 = errors;
        load_expected(32'h100, 12);
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        finish_test("reset to boot address", err0);
        redirect_test("backward branch and jal", 1, 0, 0, 32'h200, 0, 0, 12, 0);
        redirect_test("forward branch and jalr", 1, 0, 0, 32'h400, 0, 0, 12, 0);
        redirect_test("random back-pressure", 1, 0, 0, 32'h200, 0, 0, 16, 1);
        redirect_test("mispredict", 1, 0, 0, 32'h504, 0, 0, 8, 0);
        redirect_test("eret", 0, 1, 0, 0, 32'h604, 0, 8, 0);
        redirect_test("exception", 0, 0, 1, 0, 0, 32'h708, 8, 0);
        redirect_test("all redirects at once", 1, 1, 1, 32'h500, 32'h600, 32'h710, 8, 0);
        redirect_test("eret over mispredict", 1, 1, 0, 32'h500, 32'h60c, 0, 8, 0);
        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/fe_pkg.sv
rtl/fetch_reg.sv
rtl/instr_scan.sv
rtl/branch_predict.sv
rtl/instr_queue.sv
rtl/pc_gen.sv
rtl/fetch_frontend.sv
dv/tb_fetch_frontend.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_fetch_frontend \
    -f flist.f --Mdir obj_dir -o sim_fetch_frontend
status=0
./obj_dir/sim_fetch_frontend > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
